/* design/udp_cmd_pkg.sv */
package udp_cmd_pkg;

    typedef logic [47:0] mac_t;
    typedef logic [31:0] ip_t;
    typedef logic [15:0] port_t;
    typedef logic [7:0]  byte_t;
    typedef logic [23:0] flash_addr_t;

    localparam mac_t BROADCAST_MAC = 48'hffff_ffff_ffff;

    // Command ports and their reply ports
    localparam port_t PORT_REFLECT       = 16'd1234;
    localparam port_t PORT_REFLECT_REPLY = 16'd1235;
    localparam port_t PORT_FLASH_READ    = 16'heee0;
    localparam port_t PORT_FLASH_REPLY   = 16'heee1;

    // SPI flash read command and answer size
    localparam byte_t FLASH_CMD_READ   = 8'h03;
    localparam int    FLASH_READ_BYTES = 128;

    localparam int UDP_HDR_BYTES = 8;

endpackage

/* design/mac_filter.sv */
module mac_filter (
    input  logic              clk,
    input  logic              rst,
    input  logic              rx_hdr_valid,
    input  udp_cmd_pkg::mac_t rx_dest_mac,
    input  udp_cmd_pkg::mac_t local_mac,
    output logic              match,
    output logic              match_valid
);
    import udp_cmd_pkg::*;

    logic [11:0] nib_eq;
    logic [3:0]  grp_bcast;
    logic        hdr_d1;

    // Stage one compares narrow slices
    always_ff @(posedge clk) begin
        for (int i = 0; i < 12; i++) begin
            nib_eq[i] <= rx_dest_mac[i*4 +: 4] == local_mac[i*4 +: 4];
        end
        for (int g = 0; g < 4; g++) begin
            grp_bcast[g] <= rx_dest_mac[g*12 +: 12] == BROADCAST_MAC[g*12 +: 12];
        end
        // Stage two
        match <= (&nib_eq) | (&grp_bcast);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_d1      <= 1'b0;
            match_valid <= 1'b0;
        end else begin
            hdr_d1      <= rx_hdr_valid;
            match_valid <= hdr_d1 & rx_hdr_valid;
        end
    end

endmodule

/* design/spi_flash_reader.sv */
module spi_flash_reader #(
    parameter int SPI_CLK_DIV = 2
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  udp_cmd_pkg::flash_addr_t start_addr,
    output logic                     spi_sck,
    output logic                     spi_mosi,
    output logic                     spi_cs,
    input  logic                     spi_miso,
    output udp_cmd_pkg::byte_t       flash_data,
    output logic                     flash_valid,
    input  logic                     flash_ready,
    output logic                     done
);
    import udp_cmd_pkg::*;

    localparam int DIV_W  = $clog2(SPI_CLK_DIV + 1);
    localparam int BYTE_W = $clog2(FLASH_READ_BYTES + 1);

    typedef enum logic [1:0] {st_idle, st_cmd, st_data, st_last} state_t;

    state_t            state;
    logic [DIV_W-1:0]  div_cnt;
    logic [4:0]        bit_cnt;
    logic [BYTE_W-1:0] byte_cnt;
    logic [31:0]       shift_out;
    byte_t             shift_in;
    logic              tick;
    logic              hold;

    assign tick = div_cnt == DIV_W'(SPI_CLK_DIV - 1);
    // SCK parks low at a byte boundary until the previous byte is taken
    assign hold = (state == st_data) && (bit_cnt == 5'd0) && !spi_sck
                  && flash_valid && !flash_ready;
    assign spi_mosi = (state == st_cmd) ? shift_out[31] : 1'b0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= st_idle;
            spi_cs      <= 1'b1;
            spi_sck     <= 1'b0;
            flash_valid <= 1'b0;
            done        <= 1'b0;
            div_cnt     <= '0;
            bit_cnt     <= '0;
            byte_cnt    <= '0;
        end else begin
            done <= 1'b0;
            if (flash_valid && flash_ready) begin
                flash_valid <= 1'b0;
            end
            case (state)
                st_idle: begin
                    if (start) begin
                        shift_out <= {FLASH_CMD_READ, start_addr};
                        spi_cs    <= 1'b0;
                        div_cnt   <= '0;
                        bit_cnt   <= '0;
                        byte_cnt  <= '0;
                        state     <= st_cmd;
                    end
                end
                st_cmd, st_data: begin
                    if (!hold && !tick) begin
                        div_cnt <= div_cnt + 1'b1;
                    end else if (!hold) begin
                        div_cnt <= '0;
                        spi_sck <= !spi_sck;
                        if (!spi_sck) begin
                            // Rising edge samples MISO
                            shift_in <= {shift_in[6:0], spi_miso};
                        end else if (state == st_cmd) begin
                            shift_out <= {shift_out[30:0], 1'b0};
                            bit_cnt   <= bit_cnt + 1'b1;
                            if (bit_cnt == 5'd31) begin
                                bit_cnt <= '0;
                                state   <= st_data;
                            end
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 5'd7) begin
                                bit_cnt     <= '0;
                                flash_data  <= shift_in;
                                flash_valid <= 1'b1;
                                byte_cnt    <= byte_cnt + 1'b1;
                                if (byte_cnt == BYTE_W'(FLASH_READ_BYTES - 1)) begin
                                    state <= st_last;
                                end
                            end
                        end
                    end
                end
                st_last: begin
                    // Release the flash once the final byte is gone
                    if (!flash_valid || flash_ready) begin
                        spi_cs <= 1'b1;
                        done   <= 1'b1;
                        state  <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

/* design/payload_fifo.sv */
module payload_fifo #(
    parameter int FIFO_DEPTH = 256
) (
    input  logic               clk,
    input  logic               rst,
    input  udp_cmd_pkg::byte_t in_data,
    input  logic               in_last,
    input  logic               in_valid,
    output logic               in_ready,
    output udp_cmd_pkg::byte_t out_data,
    output logic               out_last,
    output logic               out_valid,
    input  logic               out_ready
);
    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    // Last flag stored above the data byte
    logic [8:0]       mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    assign in_ready  = count != CNT_W'(FIFO_DEPTH);
    assign out_valid = count != '0;
    assign wr_en     = in_valid && in_ready;
    assign rd_en     = out_valid && out_ready;
    assign {out_last, out_data} = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= {in_last, in_data};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(wr_en) - CNT_W'(rd_en);
        end
    end

endmodule

/* design/cmd_dispatcher.sv */
module cmd_dispatcher (
    input  logic                     clk,
    input  logic                     rst,
    input  udp_cmd_pkg::ip_t         local_ip,
    input  logic                     rx_hdr_valid,
    output logic                     rx_hdr_ready,
    input  udp_cmd_pkg::ip_t         rx_src_ip,
    input  udp_cmd_pkg::port_t       rx_dest_port,
    input  udp_cmd_pkg::port_t       rx_length,
    input  udp_cmd_pkg::byte_t       rx_data,
    input  logic                     rx_valid,
    output logic                     rx_ready,
    input  logic                     rx_last,
    input  logic                     match,
    input  logic                     match_valid,
    output logic                     start,
    output udp_cmd_pkg::flash_addr_t start_addr,
    input  udp_cmd_pkg::byte_t       flash_data,
    input  logic                     flash_valid,
    output logic                     flash_ready,
    input  logic                     done,
    output udp_cmd_pkg::byte_t       fifo_data,
    output logic                     fifo_last,
    output logic                     fifo_valid,
    input  logic                     fifo_ready,
    output logic                     tx_hdr_valid,
    input  logic                     tx_hdr_ready,
    output udp_cmd_pkg::ip_t         tx_src_ip,
    output udp_cmd_pkg::ip_t         tx_dest_ip,
    output udp_cmd_pkg::port_t       tx_src_port,
    output udp_cmd_pkg::port_t       tx_dest_port,
    output udp_cmd_pkg::port_t       tx_length
);
    import udp_cmd_pkg::*;

    localparam int CNT_W = $clog2(FLASH_READ_BYTES);

    typedef enum logic [2:0] {
        st_idle, st_drain, st_reflect, st_addr, st_flash, st_hdr_wait
    } state_t;

    state_t           state;
    logic [1:0]       addr_cnt;
    logic [CNT_W-1:0] flash_cnt;
    logic             rx_xfer;

    assign rx_xfer = rx_valid && rx_ready;

    // No payload moves while the header handshake is in progress
    always_comb begin
        rx_ready    = 1'b0;
        fifo_valid  = 1'b0;
        fifo_data   = rx_data;
        fifo_last   = rx_last;
        flash_ready = 1'b0;
        case (state)
            st_drain, st_addr: rx_ready = !rx_hdr_ready;
            st_reflect: begin
                rx_ready   = fifo_ready && !rx_hdr_ready;
                fifo_valid = rx_valid && !rx_hdr_ready;
            end
            st_flash: begin
                fifo_valid  = flash_valid;
                fifo_data   = flash_data;
                fifo_last   = flash_cnt == CNT_W'(FLASH_READ_BYTES - 1);
                flash_ready = fifo_ready;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= st_idle;
            rx_hdr_ready <= 1'b0;
            tx_hdr_valid <= 1'b0;
            start        <= 1'b0;
        end else begin
            rx_hdr_ready <= 1'b0;
            start        <= 1'b0;
            if (tx_hdr_valid && tx_hdr_ready) begin
                tx_hdr_valid <= 1'b0;
            end
            case (state)
                st_idle: begin
                    if (rx_hdr_valid && match_valid) begin
                        rx_hdr_ready <= 1'b1;
                        tx_src_ip    <= local_ip;
                        tx_dest_ip   <= rx_src_ip;
                        state        <= st_drain;
                        if (match && rx_dest_port == PORT_REFLECT) begin
                            tx_src_port  <= PORT_REFLECT;
                            tx_dest_port <= PORT_REFLECT_REPLY;
                            tx_length    <= rx_length;
                            tx_hdr_valid <= 1'b1;
                            state        <= st_reflect;
                        end else if (match && rx_dest_port == PORT_FLASH_READ) begin
                            tx_src_port  <= PORT_FLASH_READ;
                            tx_dest_port <= PORT_FLASH_REPLY;
                            tx_length    <= port_t'(FLASH_READ_BYTES + UDP_HDR_BYTES);
                            tx_hdr_valid <= 1'b1;
                            addr_cnt     <= '0;
                            state        <= st_addr;
                        end
                    end
                end
                st_drain: begin
                    if (rx_xfer && rx_last) begin
                        state <= st_idle;
                    end
                end
                st_reflect: begin
                    if (rx_xfer && rx_last) begin
                        state <= st_hdr_wait;
                    end
                end
                st_addr: begin
                    if (rx_xfer) begin
                        // Address arrives LSB first
                        if (addr_cnt != 2'd3) begin
                            start_addr <= {rx_data, start_addr[23:8]};
                            addr_cnt   <= addr_cnt + 1'b1;
                        end
                        if (rx_last) begin
                            start     <= 1'b1;
                            flash_cnt <= '0;
                            state     <= st_flash;
                        end
                    end
                end
                st_flash: begin
                    if (flash_valid && fifo_ready) begin
                        flash_cnt <= flash_cnt + 1'b1;
                    end
                    if (done) begin
                        state <= st_hdr_wait;
                    end
                end
                st_hdr_wait: begin
                    if (!tx_hdr_valid || tx_hdr_ready) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

/* design/udp_responder_top.sv */
module udp_responder_top #(
    parameter int SPI_CLK_DIV = 2,
    parameter int FIFO_DEPTH  = 256
) (
    input  logic               clk,
    input  logic               rst,
    input  udp_cmd_pkg::mac_t  local_mac,
    input  udp_cmd_pkg::ip_t   local_ip,
    input  logic               rx_hdr_valid,
    output logic               rx_hdr_ready,
    input  udp_cmd_pkg::mac_t  rx_dest_mac,
    input  udp_cmd_pkg::ip_t   rx_src_ip,
    input  udp_cmd_pkg::port_t rx_dest_port,
    input  udp_cmd_pkg::port_t rx_length,
    input  udp_cmd_pkg::byte_t rx_data,
    input  logic               rx_valid,
    output logic               rx_ready,
    input  logic               rx_last,
    output logic               tx_hdr_valid,
    input  logic               tx_hdr_ready,
    output udp_cmd_pkg::ip_t   tx_src_ip,
    output udp_cmd_pkg::ip_t   tx_dest_ip,
    output udp_cmd_pkg::port_t tx_src_port,
    output udp_cmd_pkg::port_t tx_dest_port,
    output udp_cmd_pkg::port_t tx_length,
    output udp_cmd_pkg::byte_t tx_data,
    output logic               tx_valid,
    input  logic               tx_ready,
    output logic               tx_last,
    output logic               spi_sck,
    output logic               spi_mosi,
    output logic               spi_cs,
    input  logic               spi_miso
);
    import udp_cmd_pkg::*;

    logic        match;
    logic        match_valid;
    logic        start;
    flash_addr_t start_addr;
    byte_t       flash_data;
    logic        flash_valid;
    logic        flash_ready;
    logic        done;
    byte_t       fifo_data;
    logic        fifo_last;
    logic        fifo_valid;
    logic        fifo_ready;

    mac_filter u_mac_filter (
        .clk          (clk),
        .rst          (rst),
        .rx_hdr_valid (rx_hdr_valid),
        .rx_dest_mac  (rx_dest_mac),
        .local_mac    (local_mac),
        .match        (match),
        .match_valid  (match_valid)
    );

    cmd_dispatcher u_dispatcher (
        .clk          (clk),
        .rst          (rst),
        .local_ip     (local_ip),
        .rx_hdr_valid (rx_hdr_valid),
        .rx_hdr_ready (rx_hdr_ready),
        .rx_src_ip    (rx_src_ip),
        .rx_dest_port (rx_dest_port),
        .rx_length    (rx_length),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_ready     (rx_ready),
        .rx_last      (rx_last),
        .match        (match),
        .match_valid  (match_valid),
        .start        (start),
        .start_addr   (start_addr),
        .flash_data   (flash_data),
        .flash_valid  (flash_valid),
        .flash_ready  (flash_ready),
        .done         (done),
        .fifo_data    (fifo_data),
        .fifo_last    (fifo_last),
        .fifo_valid   (fifo_valid),
        .fifo_ready   (fifo_ready),
        .tx_hdr_valid (tx_hdr_valid),
        .tx_hdr_ready (tx_hdr_ready),
        .tx_src_ip    (tx_src_ip),
        .tx_dest_ip   (tx_dest_ip),
        .tx_src_port  (tx_src_port),
        .tx_dest_port (tx_dest_port),
        .tx_length    (tx_length)
    );

    spi_flash_reader #(
        .SPI_CLK_DIV (SPI_CLK_DIV)
    ) u_flash_reader (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .start_addr  (start_addr),
        .spi_sck     (spi_sck),
        .spi_mosi    (spi_mosi),
        .spi_cs      (spi_cs),
        .spi_miso    (spi_miso),
        .flash_data  (flash_data),
        .flash_valid (flash_valid),
        .flash_ready (flash_ready),
        .done        (done)
    );

    // All answers share one payload queue
    payload_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_payload_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_data   (fifo_data),
        .in_last   (fifo_last),
        .in_valid  (fifo_valid),
        .in_ready  (fifo_ready),
        .out_data  (tx_data),
        .out_last  (tx_last),
        .out_valid (tx_valid),
        .out_ready (tx_ready)
    );

endmodule

/* dv/flash_model.sv */
module flash_model (
    input  logic        spi_sck,
    input  logic        spi_mosi,
    input  logic        spi_cs,
    output logic        spi_miso,
    output logic [31:0] cmd_word,
    output logic        cmd_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned bit_cnt  = 0;
    logic        miso_q   = 1'b0;
    logic        cmd_done = 1'b0;

    assign spi_miso  = miso_q;
    assign cmd_valid = cmd_done;

    // Mode 0 command and address are sampled on rising SCK
    always @(posedge spi_sck or posedge spi_cs) begin
        if (spi_cs) begin
            bit_cnt  <= 0;
            cmd_done <= 1'b0;
        end else begin
            if (bit_cnt < 32) begin
                cmd_word <= {cmd_word[30:0], spi_mosi};
            end
            if (bit_cnt == 31) begin
                cmd_done <= 1'b1;
            end
            bit_cnt <= bit_cnt + 1;
        end
    end

    // Byte at address a is a[7:0] ^ 0x5a and leaves MSB first on falling SCK
    always @(negedge spi_sck) begin
        int unsigned n;
        logic [23:0] a;
        logic [7:0]  d;
        if (bit_cnt >= 32) begin
            n = bit_cnt - 32;
            a = cmd_word[23:0] + 24'(n / 8);
            d = (a[7:0] ^ 8'h5a) << (n % 8);
            miso_q <= d[7];
        end
    end

endmodule

/* dv/tb_top.sv */
module tb_top;
    timeunit 1ns;
    timeprecision 100ps;

    import udp_cmd_pkg::*;

    localparam int          CLK_PERIOD  = 100;
    localparam int          SPI_CLK_DIV = 2;
    localparam int          FIFO_DEPTH  = 256;
    localparam int          NUM_RANDOM  = 20;
    localparam int          NUM_PACKETS = NUM_RANDOM + 5;
    localparam int          READ_LEN    = 128;
    localparam int          FLASH_READ_CYCLES = (32 + 8 * READ_LEN) * 2 * SPI_CLK_DIV;
    localparam int          WATCHDOG_NS = NUM_PACKETS * FLASH_READ_CYCLES * 2 * CLK_PERIOD
                                          + 1000 * CLK_PERIOD;
    localparam logic [31:0] SEED        = 32'h90b291e0;
    localparam mac_t        LOCAL_MAC   = 48'h02_12_34_56_78_9a;
    localparam ip_t         LOCAL_IP    = 32'hc0a8_0164;

    // Datagram kinds
    localparam int K_REFLECT   = 0;
    localparam int K_BCAST     = 1;
    localparam int K_FLASH     = 2;
    localparam int K_WRONG_MAC = 3;
    localparam int K_BAD_PORT  = 4;

    typedef struct packed {
        ip_t   src_ip;
        ip_t   dest_ip;
        port_t src_port;
        port_t dest_port;
        port_t length;
    } tx_hdr_t;

    logic  clk;
    logic  rst;
    mac_t  local_mac;
    ip_t   local_ip;
    logic  rx_hdr_valid, rx_hdr_ready;
    mac_t  rx_dest_mac;
    ip_t   rx_src_ip;
    port_t rx_dest_port, rx_length;
    byte_t rx_data;
    logic  rx_valid, rx_ready, rx_last;
    logic  tx_hdr_valid, tx_hdr_ready;
    ip_t   tx_src_ip, tx_dest_ip;
    port_t tx_src_port, tx_dest_port, tx_length;
    byte_t tx_data;
    logic  tx_valid, tx_ready, tx_last;
    logic  spi_sck, spi_mosi, spi_cs, spi_miso;
    logic  [31:0] cmd_word;
    logic  cmd_valid;

    tx_hdr_t     exp_hdr[$];
    logic [8:0]  exp_bytes[$];
    flash_addr_t exp_addr[$];
    byte_t       payload[$];
    logic        first_hdr_sent = 1'b0;
    logic        hdr_pending;
    logic        cmd_seen;

    udp_responder_top #(
        .SPI_CLK_DIV (SPI_CLK_DIV),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) UUT (
        .clk (clk), .rst (rst), .local_mac (local_mac), .local_ip (local_ip),
        .rx_hdr_valid (rx_hdr_valid), .rx_hdr_ready (rx_hdr_ready),
        .rx_dest_mac (rx_dest_mac), .rx_src_ip (rx_src_ip),
        .rx_dest_port (rx_dest_port), .rx_length (rx_length),
        .rx_data (rx_data), .rx_valid (rx_valid), .rx_ready (rx_ready), .rx_last (rx_last),
        .tx_hdr_valid (tx_hdr_valid), .tx_hdr_ready (tx_hdr_ready),
        .tx_src_ip (tx_src_ip), .tx_dest_ip (tx_dest_ip), .tx_src_port (tx_src_port),
        .tx_dest_port (tx_dest_port), .tx_length (tx_length),
        .tx_data (tx_data), .tx_valid (tx_valid), .tx_ready (tx_ready), .tx_last (tx_last),
        .spi_sck (spi_sck), .spi_mosi (spi_mosi), .spi_cs (spi_cs), .spi_miso (spi_miso)
    );

    flash_model u_flash (
        .spi_sck (spi_sck), .spi_mosi (spi_mosi), .spi_cs (spi_cs), .spi_miso (spi_miso),
        .cmd_word (cmd_word), .cmd_valid (cmd_valid)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
        assert (got == expected)
            else fail_run($sformatf("MISMATCH at %0t ns: %s got 0x%0h, expected 0x%0h",
                                    $time, name, got, expected));
    endtask

    task automatic send_header(mac_t mac, ip_t ip, port_t port, port_t len);
        logic accepted;
        first_hdr_sent = 1'b1;
        rx_dest_mac    = mac;
        rx_src_ip      = ip;
        rx_dest_port   = port;
        rx_length      = len;
        rx_hdr_valid   = 1'b1;
        accepted       = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = rx_hdr_ready;
            @(posedge clk);
            #1;
        end
        rx_hdr_valid = 1'b0;
    endtask

    task automatic send_payload();
        logic taken;
        for (int i = 0; i < payload.size(); i++) begin
            rx_data  = payload[i];
            rx_last  = (i == payload.size() - 1);
            rx_valid = 1'b1;
            taken    = 1'b0;
            while (!taken) begin
                @(negedge clk);
                taken = rx_ready;
                @(posedge clk);
                #1;
            end
        end
        rx_valid = 1'b0;
        rx_last  = 1'b0;
    endtask

    // Builds one datagram, queues its expected answer and sends it
    task automatic send_datagram(int kind);
        mac_t        mac;
        ip_t         src_ip;
        port_t       port;
        int          len;
        flash_addr_t addr;
        tx_hdr_t     h;
        src_ip = $urandom;
        mac    = LOCAL_MAC;
        port   = 16'd1234;
        len    = $urandom_range(1, 48);
        case (kind)
            K_BCAST:     mac = 48'hffff_ffff_ffff;
            K_WRONG_MAC: mac = LOCAL_MAC ^ 48'($urandom_range(1, 255));
            K_BAD_PORT:  port = 16'($urandom_range(1, 1000));
            K_FLASH: begin
                port = 16'heee0;
                len  = $urandom_range(3, 6);
            end
            default: ;
        endcase
        payload.delete();
        for (int i = 0; i < len; i++) begin
            payload.push_back(8'($urandom));
        end
        h.src_ip  = LOCAL_IP;
        h.dest_ip = src_ip;
        if (kind == K_REFLECT || kind == K_BCAST) begin
            h.src_port  = 16'd1234;
            h.dest_port = 16'd1235;
            h.length    = 16'(len + 8);
            exp_hdr.push_back(h);
            for (int i = 0; i < len; i++) begin
                exp_bytes.push_back({i == len - 1, payload[i]});
            end
        end else if (kind == K_FLASH) begin
            addr        = {payload[2], payload[1], payload[0]};
            h.src_port  = 16'heee0;
            h.dest_port = 16'heee1;
            h.length    = 16'd136;
            exp_hdr.push_back(h);
            exp_addr.push_back(addr);
            for (int i = 0; i < READ_LEN; i++) begin
                exp_bytes.push_back({i == READ_LEN - 1, 8'(addr + 24'(i)) ^ 8'h5a});
            end
        end
        send_header(mac, src_ip, port, 16'(len + 8));
        send_payload();
    endtask

    // Random downstream stalls
    initial begin
        tx_ready     = 1'b0;
        tx_hdr_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            tx_ready     = $urandom_range(0, 3) != 0;
            tx_hdr_ready = $urandom_range(0, 1) == 1;
        end
    end

    assert property (@(negedge clk)
        !first_hdr_sent |-> !tx_hdr_valid && !tx_valid && !rx_hdr_ready && spi_cs)
        else fail_run("Outputs became active after reset before any header was sent");

    assert property (@(negedge clk) disable iff (rst) rx_hdr_ready |-> rx_hdr_valid)
        else fail_run("rx_hdr_ready raised while no header was offered");

    // Scoreboard sampled mid-cycle
    always @(negedge clk) begin
        tx_hdr_t     h;
        logic [8:0]  b;
        flash_addr_t a;
        if (rst) begin
            hdr_pending = 1'b0;
            cmd_seen    = 1'b0;
        end else begin
            assert (!hdr_pending || tx_hdr_valid)
                else fail_run("tx_hdr_valid dropped before tx_hdr_ready was seen");
            if (tx_hdr_valid && tx_hdr_ready) begin
                if (exp_hdr.size() == 0) begin
                    fail_run("A tx header was sent where no answer was expected");
                end else begin
                    h = exp_hdr.pop_front();
                    check_value("tx_src_ip", tx_src_ip, h.src_ip);
                    check_value("tx_dest_ip", tx_dest_ip, h.dest_ip);
                    check_value("tx_src_port", 32'(tx_src_port), 32'(h.src_port));
                    check_value("tx_dest_port", 32'(tx_dest_port), 32'(h.dest_port));
                    check_value("tx_length", 32'(tx_length), 32'(h.length));
                end
            end
            if (tx_valid && tx_ready) begin
                if (exp_bytes.size() == 0) begin
                    fail_run("A payload byte was sent where none was expected");
                end else begin
                    b = exp_bytes.pop_front();
                    check_value("tx_data", 32'(tx_data), 32'(b[7:0]));
                    check_value("tx_last", 32'(tx_last), 32'(b[8]));
                end
            end
            if (cmd_valid && !cmd_seen) begin
                if (exp_addr.size() == 0) begin
                    fail_run("The flash saw a read command that no datagram asked for");
                end else begin
                    a = exp_addr.pop_front();
                    check_value("flash command", 32'(cmd_word[31:24]), 32'h03);
                    check_value("flash address", 32'(cmd_word[23:0]), 32'(a));
                end
            end
            hdr_pending = tx_hdr_valid && !tx_hdr_ready;
            cmd_seen    = cmd_valid;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        fail_run("Timeout: the responder did not finish all answers in time");
    end

    initial begin
        void'($urandom(SEED));
        rst          = 1'b1;
        local_mac    = LOCAL_MAC;
        local_ip     = LOCAL_IP;
        rx_hdr_valid = 1'b0;
        rx_dest_mac  = '0;
        rx_src_ip    = '0;
        rx_dest_port = '0;
        rx_length    = '0;
        rx_data      = '0;
        rx_valid     = 1'b0;
        rx_last      = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        send_datagram(K_REFLECT);
        send_datagram(K_BCAST);
        send_datagram(K_WRONG_MAC);
        send_datagram(K_BAD_PORT);
        send_datagram(K_FLASH);
        // Back-to-back mixed traffic
        for (int n = 0; n < NUM_RANDOM; n++) begin
            send_datagram($urandom_range(0, 4));
        end
        while (exp_hdr.size() != 0 || exp_bytes.size() != 0 || exp_addr.size() != 0) begin
            @(negedge clk);
        end
        repeat (50) @(negedge clk);
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* build.f */
design/udp_cmd_pkg.sv
design/mac_filter.sv
design/spi_flash_reader.sv
design/payload_fifo.sv
design/cmd_dispatcher.sv
design/udp_responder_top.sv
dv/flash_model.sv
dv/tb_top.sv

/* run.sh */
#!/bin/sh
# Compile and run the testbench with Verilator, then scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_top -Mdir obj_dir -o tb_sim -f build.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG" || exit 1

if grep -q "ERRORS FOUND" "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi
echo "Simulation passed"
exit 0
